//--- hdl/fir_cfg.svh
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// ==================================================
// Filter geometry
// ==================================================
`define FIR_TAPS        4
`define FIR_MAC_CYCLES  4

// ==================================================
// Register map, byte addresses
// ==================================================
`define ADDR_STATUS     0
`define ADDR_RESULT     2
`define ADDR_SAMPLE     4
// Coefficient k sits at ADDR_COEFF0 + 2k, up to address 13
`define ADDR_COEFF0     6
`define ADDR_NEW_COEFF  14

// Status word layout, busy is bit 0
`define STATUS_ERR_BIT  8

`endif

//--- hdl/fir_pkg.sv
`default_nettype none

package fir_pkg;

    // Sample, coefficient and result words
    typedef logic signed [15:0] sample_t;

    // Register byte address on the bus
    typedef logic [3:0] reg_addr_t;

    // Coefficient or tap index
    typedef logic [1:0] coeff_idx_t;

    // Four 32-bit products need two guard bits
    typedef logic signed [33:0] acc_t;

    // Coefficient loader
    typedef enum logic [1:0] {L_IDLE, L_LOAD, L_DONE} load_state_t;

    // MAC sequencer
    typedef enum logic [1:0] {M_IDLE, M_MAC, M_WRITE} mac_state_t;

endpackage

`default_nettype wire

//--- hdl/ahb_lite_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module ahb_lite_slave (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hsel,
    input  fir_pkg::reg_addr_t  haddr,
    input  logic                hsize,
    input  logic [1:0]          htrans,
    input  logic                hwrite,
    input  fir_pkg::sample_t    hwdata,
    input  logic                modwait,
    input  fir_pkg::sample_t    fir_out,
    input  logic                err,
    input  fir_pkg::coeff_idx_t coefficient_num,
    input  logic                clear_coeff_set,
    output fir_pkg::sample_t    hrdata,
    output logic                hresp,
    output fir_pkg::sample_t    sample_data,
    output logic                data_ready,
    output logic                new_coefficient_set,
    output fir_pkg::sample_t    fir_coefficient
);
    import fir_pkg::*;

    // Halfword index of each register
    localparam logic [2:0] WORD_STATUS = 3'(`ADDR_STATUS / 2);
    localparam logic [2:0] WORD_RESULT = 3'(`ADDR_RESULT / 2);
    localparam logic [2:0] WORD_SAMPLE = 3'(`ADDR_SAMPLE / 2);
    localparam logic [2:0] WORD_COEFF0 = 3'(`ADDR_COEFF0 / 2);
    localparam logic [2:0] WORD_FLAG   = 3'(`ADDR_NEW_COEFF / 2);

    reg_addr_t  dp_addr;
    logic       dp_size;
    logic       dp_write;
    logic       dp_valid;

    sample_t    sample_q;
    sample_t    coeff_q [`FIR_TAPS];

    sample_t    sample_next;
    sample_t    coeff_next [`FIR_TAPS];
    logic       flag_next;

    logic       ap_valid;
    logic [2:0] ap_word;
    logic       wr_en;
    logic [2:0] dp_word;
    logic [1:0] dp_lanes;
    sample_t    status_word;
    sample_t    rd_word;
    sample_t    rd_value;

    // Replace only the enabled byte lanes
    function automatic sample_t merge_lanes(sample_t old_v, sample_t new_v, logic [1:0] lanes);
        sample_t merged;
        merged = old_v;
        if (lanes[0]) begin
            merged[7:0] = new_v[7:0];
        end
        if (lanes[1]) begin
            merged[15:8] = new_v[15:8];
        end
        return merged;
    endfunction

    // ==================================================
    // Address phase
    // ==================================================
    assign ap_valid = hsel && (htrans != 2'b00);
    assign ap_word  = haddr[3:1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
            dp_size  <= 1'b0;
            dp_addr  <= '0;
        end else begin
            dp_valid <= ap_valid;
            dp_write <= hwrite;
            dp_size  <= hsize;
            dp_addr  <= haddr;
        end
    end

    // ==================================================
    // Data phase writes
    // ==================================================
    assign wr_en    = dp_valid && dp_write;
    assign dp_word  = dp_addr[3:1];
    // Odd halfword addresses fold onto the even pair
    assign dp_lanes = dp_size ? 2'b11 : (dp_addr[0] ? 2'b10 : 2'b01);

    always_comb begin
        sample_next = sample_q;
        flag_next   = clear_coeff_set ? 1'b0 : new_coefficient_set;
        for (int i = 0; i < `FIR_TAPS; i++) begin
            coeff_next[i] = coeff_q[i];
        end
        if (wr_en) begin
            if (dp_word == WORD_SAMPLE) begin
                sample_next = merge_lanes(sample_q, hwdata, dp_lanes);
            end
            for (int i = 0; i < `FIR_TAPS; i++) begin
                if (dp_word == WORD_COEFF0 + 3'(i)) begin
                    coeff_next[i] = merge_lanes(coeff_q[i], hwdata, dp_lanes);
                end
            end
            // Bus write wins over the loader clear
            if ((dp_word == WORD_FLAG) && dp_lanes[0]) begin
                flag_next = hwdata[0];
            end
        end
    end

    assign hresp      = wr_en && ((dp_word == WORD_STATUS) || (dp_word == WORD_RESULT));
    assign data_ready = wr_en && (dp_word == WORD_SAMPLE);
    assign sample_data = sample_next;

    assign fir_coefficient = coeff_q[coefficient_num];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_q            <= '0;
            new_coefficient_set <= 1'b0;
            for (int i = 0; i < `FIR_TAPS; i++) begin
                coeff_q[i] <= '0;
            end
        end else begin
            sample_q            <= sample_next;
            new_coefficient_set <= flag_next;
            for (int i = 0; i < `FIR_TAPS; i++) begin
                coeff_q[i] <= coeff_next[i];
            end
        end
    end

    // ==================================================
    // Read path
    // ==================================================
    always_comb begin
        status_word                  = '0;
        status_word[0]               = modwait || flag_next;
        status_word[`STATUS_ERR_BIT] = err;
    end

    // Next-state values give back the write still in its data phase
    always_comb begin
        rd_word = '0;
        if (ap_word == WORD_STATUS) begin
            rd_word = status_word;
        end else if (ap_word == WORD_RESULT) begin
            rd_word = fir_out;
        end else if (ap_word == WORD_SAMPLE) begin
            rd_word = sample_next;
        end else if (ap_word == WORD_FLAG) begin
            rd_word = {15'b0, flag_next};
        end
        for (int i = 0; i < `FIR_TAPS; i++) begin
            if (ap_word == WORD_COEFF0 + 3'(i)) begin
                rd_word = coeff_next[i];
            end
        end
    end

    always_comb begin
        if (hsize) begin
            rd_value = rd_word;
        end else if (haddr[0]) begin
            rd_value = {rd_word[15:8], 8'h00};
        end else begin
            rd_value = {8'h00, rd_word[7:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hrdata <= '0;
        end else if (ap_valid && !hwrite) begin
            hrdata <= rd_value;
        end
    end

    // Read-only error never strobes a sample
    a_resp_ready_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(hresp && data_ready)
    ) else $error("hresp and data_ready high together");

    a_ready_after_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        data_ready |-> $past(hsel && (htrans != 2'b00) && hwrite)
    ) else $error("data_ready outside a write data phase");

endmodule

`default_nettype wire

//--- hdl/coefficient_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module coefficient_loader (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                new_coefficient_set,
    input  logic                modwait,
    output fir_pkg::coeff_idx_t coefficient_num,
    output logic                load_coeff,
    output logic                clear_coeff_set
);
    import fir_pkg::*;

    localparam coeff_idx_t LAST_TAP = coeff_idx_t'(`FIR_TAPS - 1);

    load_state_t state_q;
    load_state_t state_next;
    coeff_idx_t  count_q;

    always_comb begin
        state_next = state_q;
        case (state_q)
            L_IDLE: begin
                // Only start between samples
                if (new_coefficient_set && !modwait) begin
                    state_next = L_LOAD;
                end
            end
            L_LOAD: begin
                if (count_q == LAST_TAP) begin
                    state_next = L_DONE;
                end
            end
            L_DONE: begin
                state_next = L_IDLE;
            end
            default: begin
                state_next = L_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= L_IDLE;
            count_q <= '0;
        end else begin
            state_q <= state_next;
            if (state_q == L_LOAD) begin
                count_q <= count_q + 1'b1;
            end else begin
                count_q <= '0;
            end
        end
    end

    assign coefficient_num = count_q;
    assign load_coeff      = (state_q == L_LOAD);
    assign clear_coeff_set = (state_q == L_DONE);

endmodule

`default_nettype wire

//--- hdl/fir_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module fir_datapath (
    input  logic                clk,
    input  logic                rst_n,
    input  fir_pkg::sample_t    sample_data,
    input  logic                data_ready,
    input  logic                load_coeff,
    input  fir_pkg::coeff_idx_t coefficient_num,
    input  fir_pkg::sample_t    fir_coefficient,
    output logic                modwait,
    output fir_pkg::sample_t    fir_out,
    output logic                err
);
    import fir_pkg::*;

    localparam coeff_idx_t LAST_TAP = coeff_idx_t'(`FIR_MAC_CYCLES - 1);
    localparam sample_t    SAT_MAX  = 16'sh7fff;
    localparam sample_t    SAT_MIN  = 16'sh8000;

    mac_state_t state_q;
    sample_t    coeff_q [`FIR_TAPS];
    sample_t    hist_q [`FIR_TAPS];
    coeff_idx_t tap_q;
    acc_t       acc_q;
    logic       drop_q;

    logic               idle;
    logic               accept;
    logic               drop;
    sample_t            mul_sample;
    logic signed [31:0] product;
    acc_t               acc_base;
    acc_t               acc_sum;
    logic signed [18:0] scaled;
    logic               sat_hi;
    logic               sat_lo;
    sample_t            result;

    assign idle    = (state_q == M_IDLE);
    assign accept  = data_ready && idle;
    assign drop    = data_ready && !idle;
    assign modwait = !idle;

    // ==================================================
    // Shared multiplier
    // ==================================================
    // tap_q rests at 0 while idle, so tap 0 takes the sample straight from the bus
    assign mul_sample = idle ? sample_data : hist_q[tap_q];
    assign product    = coeff_q[tap_q] * mul_sample;

    assign acc_base = idle ? '0 : acc_q;
    assign acc_sum  = acc_base + acc_t'(product);

    // ==================================================
    // Scaling and saturation
    // ==================================================
    assign scaled = acc_q[33:15];
    assign sat_hi = !scaled[18] && (scaled[17:15] != 3'b000);
    assign sat_lo = scaled[18] && (scaled[17:15] != 3'b111);

    always_comb begin
        if (sat_hi) begin
            result = SAT_MAX;
        end else if (sat_lo) begin
            result = SAT_MIN;
        end else begin
            result = scaled[15:0];
        end
    end

    // ==================================================
    // MAC sequencer
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= M_IDLE;
            tap_q   <= '0;
            acc_q   <= '0;
            drop_q  <= 1'b0;
            fir_out <= '0;
            err     <= 1'b0;
        end else begin
            case (state_q)
                M_IDLE: begin
                    if (data_ready) begin
                        acc_q   <= acc_sum;
                        tap_q   <= coeff_idx_t'(1);
                        state_q <= M_MAC;
                    end
                end
                M_MAC: begin
                    acc_q <= acc_sum;
                    tap_q <= tap_q + 1'b1;
                    if (tap_q == LAST_TAP) begin
                        state_q <= M_WRITE;
                    end
                    // Dropped sample flags at once and again with the result
                    if (drop) begin
                        err    <= 1'b1;
                        drop_q <= 1'b1;
                    end
                end
                M_WRITE: begin
                    fir_out <= result;
                    err     <= sat_hi || sat_lo || drop_q || drop;
                    drop_q  <= 1'b0;
                    state_q <= M_IDLE;
                end
                default: begin
                    state_q <= M_IDLE;
                end
            endcase
        end
    end

    // Newest sample at index 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `FIR_TAPS; k++) begin
                hist_q[k]  <= '0;
                coeff_q[k] <= '0;
            end
        end else begin
            if (accept) begin
                hist_q[0] <= sample_data;
                for (int k = 1; k < `FIR_TAPS; k++) begin
                    hist_q[k] <= hist_q[k-1];
                end
            end
            if (load_coeff) begin
                coeff_q[coefficient_num] <= fir_coefficient;
            end
        end
    end

    // Loader must never rewrite taps under a running MAC
    a_no_load_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load_coeff && modwait)
    ) else $error("coefficient load during MAC");

endmodule

`default_nettype wire

//--- hdl/fir_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module fir_filter_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hsel,
    input  fir_pkg::reg_addr_t haddr,
    input  logic               hsize,
    input  logic [1:0]         htrans,
    input  logic               hwrite,
    input  fir_pkg::sample_t   hwdata,
    output fir_pkg::sample_t   hrdata,
    output logic               hresp
);
    import fir_pkg::*;

    sample_t    sample_data;
    sample_t    fir_coefficient;
    sample_t    fir_out;
    coeff_idx_t coefficient_num;
    logic       data_ready;
    logic       new_coefficient_set;
    logic       modwait;
    logic       err;
    logic       load_coeff;
    logic       clear_coeff_set;

    ahb_lite_slave u_slave (
        .clk                 (clk),
        .rst_n               (rst_n),
        .hsel                (hsel),
        .haddr               (haddr),
        .hsize               (hsize),
        .htrans              (htrans),
        .hwrite              (hwrite),
        .hwdata              (hwdata),
        .modwait             (modwait),
        .fir_out             (fir_out),
        .err                 (err),
        .coefficient_num     (coefficient_num),
        .clear_coeff_set     (clear_coeff_set),
        .hrdata              (hrdata),
        .hresp               (hresp),
        .sample_data         (sample_data),
        .data_ready          (data_ready),
        .new_coefficient_set (new_coefficient_set),
        .fir_coefficient     (fir_coefficient)
    );

    coefficient_loader u_loader (
        .clk                 (clk),
        .rst_n               (rst_n),
        .new_coefficient_set (new_coefficient_set),
        .modwait             (modwait),
        .coefficient_num     (coefficient_num),
        .load_coeff          (load_coeff),
        .clear_coeff_set     (clear_coeff_set)
    );

    fir_datapath u_datapath (
        .clk             (clk),
        .rst_n           (rst_n),
        .sample_data     (sample_data),
        .data_ready      (data_ready),
        .load_coeff      (load_coeff),
        .coefficient_num (coefficient_num),
        .fir_coefficient (fir_coefficient),
        .modwait         (modwait),
        .fir_out         (fir_out),
        .err             (err)
    );

endmodule

`default_nettype wire

//--- sim/tb_fir_filter.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module tb_fir_filter;
    import fir_pkg::*;

    localparam int TIMEOUT = 50;

    logic       clk;
    logic       rst_n;
    logic       hsel;
    reg_addr_t  haddr;
    logic       hsize;
    logic [1:0] htrans;
    logic       hwrite;
    sample_t    hwdata;
    sample_t    hrdata;
    logic       hresp;

    int          errors;
    int          mark;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] lfsr;
    sample_t     coeff_regs [`FIR_TAPS];
    sample_t     taps [`FIR_TAPS];
    sample_t     hist [`FIR_TAPS];

    fir_filter_top uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .hsel   (hsel),
        .haddr  (haddr),
        .hsize  (hsize),
        .htrans (htrans),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hresp  (hresp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    a_hresp_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        hresp |=> !hresp
    ) else begin
        $display("hresp stayed high for more than one cycle at %0t", $time);
        errors = errors + 1;
    end

    a_busy_after_sample: assert property (
        @(posedge clk) disable iff (!rst_n)
        (uut.data_ready && !uut.modwait) |=> uut.modwait
    ) else begin
        $display("modwait did not rise after an accepted sample at %0t", $time);
        errors = errors + 1;
    end

    // ==================================================
    // Checking and reference model
    // ==================================================
    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
            errors = errors + 1;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        errors = errors + 1;
    endtask

    task automatic finish_test(input string name);
        if (errors == mark) begin
            tests_passed = tests_passed + 1;
            $display("Test %s: ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("Test %s: %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    // Byte lane picked by address bit 0, halfword covers the even pair
    function automatic sample_t apply_write(input sample_t old, input reg_addr_t addr,
                                            input logic size, input sample_t data);
        if (size) begin
            return data;
        end else if (addr[0]) begin
            return {data[15:8], old[7:0]};
        end
        return {old[15:8], data[7:0]};
    endfunction

    function automatic sample_t exp_read(input sample_t word, input reg_addr_t addr,
                                         input logic size);
        if (size) begin
            return word;
        end else if (addr[0]) begin
            return {word[15:8], 8'h00};
        end
        return {8'h00, word[7:0]};
    endfunction

    function automatic sample_t status_expect(input logic busy, input logic e);
        sample_t v;
        v = '0;
        v[0] = busy;
        v[`STATUS_ERR_BIT] = e;
        return v;
    endfunction

    task automatic model_result(output sample_t value, output logic sat);
        longint acc;
        longint scaled;
        acc = 0;
        for (int k = 0; k < `FIR_TAPS; k++) begin
            acc = acc + longint'(taps[k]) * longint'(hist[k]);
        end
        scaled = acc >>> 15;
        if (scaled > 32767) begin
            value = 16'sh7fff;
            sat = 1'b1;
        end else if (scaled < -32768) begin
            value = 16'sh8000;
            sat = 1'b1;
        end else begin
            value = sample_t'(scaled);
            sat = 1'b0;
        end
    endtask

    task automatic shift_history(input sample_t s);
        for (int k = `FIR_TAPS - 1; k > 0; k--) begin
            hist[k] = hist[k-1];
        end
        hist[0] = s;
    endtask

    // ==================================================
    // Bus transfers
    // ==================================================
    task automatic write_reg(input reg_addr_t addr, input logic size, input sample_t data,
                             output logic resp);
        @(posedge clk);
        hsel   <= 1'b1;
        haddr  <= addr;
        hsize  <= size;
        htrans <= 2'b10;
        hwrite <= 1'b1;
        @(posedge clk);
        hsel   <= 1'b0;
        htrans <= 2'b00;
        hwrite <= 1'b0;
        hwdata <= data;
        @(negedge clk);
        resp = hresp;
    endtask

    task automatic read_reg(input reg_addr_t addr, input logic size, output sample_t data);
        @(posedge clk);
        hsel   <= 1'b1;
        haddr  <= addr;
        hsize  <= size;
        htrans <= 2'b10;
        hwrite <= 1'b0;
        @(posedge clk);
        hsel   <= 1'b0;
        htrans <= 2'b00;
        @(negedge clk);
        data = hrdata;
    endtask

    task automatic wait_idle(output int cycles);
        logic done;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles = cycles + 1;
            @(negedge clk);
            if (!uut.modwait) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            report_timeout("modwait to fall");
        end
    endtask

    task automatic load_taps();
        sample_t rd;
        logic    resp;
        int      polls;
        logic    cleared;
        write_reg(reg_addr_t'(`ADDR_NEW_COEFF), 1'b1, 16'h0001, resp);
        read_reg(reg_addr_t'(`ADDR_STATUS), 1'b1, rd);
        check_value("status busy", 16'(rd[0]), 16'd1);
        polls = 0;
        cleared = 1'b0;
        while (!cleared && polls < TIMEOUT) begin
            read_reg(reg_addr_t'(`ADDR_STATUS), 1'b1, rd);
            polls = polls + 1;
            if (!rd[0]) begin
                cleared = 1'b1;
            end
        end
        if (!cleared) begin
            report_timeout("coefficient flag to clear");
        end
        read_reg(reg_addr_t'(`ADDR_NEW_COEFF), 1'b1, rd);
        check_value("new coefficient flag", rd, 16'd0);
        for (int k = 0; k < `FIR_TAPS; k++) begin
            taps[k] = coeff_regs[k];
        end
    endtask

    task automatic push_and_check(input sample_t s);
        sample_t exp_out;
        logic    exp_err;
        logic    resp;
        int      cycles;
        sample_t rd;
        shift_history(s);
        model_result(exp_out, exp_err);
        write_reg(reg_addr_t'(`ADDR_SAMPLE), 1'b1, s, resp);
        wait_idle(cycles);
        check_value("result latency", 16'(cycles), 16'd5);
        check_value("fir_out", uut.fir_out, exp_out);
        check_value("err", 16'(uut.err), 16'(exp_err));
        read_reg(reg_addr_t'(`ADDR_RESULT), 1'b1, rd);
        check_value("hrdata result", rd, exp_out);
        read_reg(reg_addr_t'(`ADDR_STATUS), 1'b1, rd);
        check_value("hrdata status", rd, status_expect(1'b0, exp_err));
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        sample_t   rd;
        sample_t   v;
        sample_t   exp_out;
        logic      exp_err;
        logic      resp;
        int        cycles;
        reg_addr_t addr;

        rst_n  = 1'b0;
        hsel   = 1'b0;
        haddr  = '0;
        hsize  = 1'b0;
        htrans = 2'b00;
        hwrite = 1'b0;
        hwdata = '0;
        lfsr   = 32'h4cbe;
        errors = 0;
        mark   = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int k = 0; k < `FIR_TAPS; k++) begin
            coeff_regs[k] = '0;
            taps[k] = '0;
            hist[k] = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        read_reg(reg_addr_t'(`ADDR_STATUS), 1'b1, rd);
        check_value("hrdata status", rd, 16'd0);
        read_reg(reg_addr_t'(`ADDR_RESULT), 1'b1, rd);
        check_value("hrdata result", rd, 16'd0);
        for (int k = 0; k < `FIR_TAPS; k++) begin
            read_reg(reg_addr_t'(`ADDR_COEFF0 + 2 * k), 1'b1, rd);
            check_value("hrdata coefficient", rd, 16'd0);
        end
        finish_test("reset values");

        // Odd coefficients go through the odd address of their pair
        for (int k = 0; k < `FIR_TAPS; k++) begin
            take_bits(16, v);
            addr = reg_addr_t'(`ADDR_COEFF0 + 2 * k + (k % 2));
            write_reg(addr, 1'b1, v, resp);
            check_value("hresp", 16'(resp), 16'd0);
            coeff_regs[k] = apply_write(coeff_regs[k], addr, 1'b1, v);
        end
        for (int k = 0; k < `FIR_TAPS; k++) begin
            read_reg(reg_addr_t'(`ADDR_COEFF0 + 2 * k), 1'b1, rd);
            check_value("hrdata coefficient", rd, coeff_regs[k]);
        end
        for (int k = 0; k < `FIR_TAPS; k++) begin
            addr = reg_addr_t'(`ADDR_COEFF0 + 2 * k);
            take_bits(16, v);
            write_reg(addr, 1'b0, v, resp);
            coeff_regs[k] = apply_write(coeff_regs[k], addr, 1'b0, v);
            take_bits(16, v);
            write_reg(addr + 1'b1, 1'b0, v, resp);
            coeff_regs[k] = apply_write(coeff_regs[k], addr + 1'b1, 1'b0, v);
            read_reg(addr, 1'b0, rd);
            check_value("hrdata low byte", rd, exp_read(coeff_regs[k], addr, 1'b0));
            read_reg(addr + 1'b1, 1'b0, rd);
            check_value("hrdata high byte", rd, exp_read(coeff_regs[k], addr + 1'b1, 1'b0));
            read_reg(addr + 1'b1, 1'b1, rd);
            check_value("hrdata coefficient", rd, coeff_regs[k]);
        end
        finish_test("coefficient access");

        write_reg(reg_addr_t'(`ADDR_STATUS), 1'b1, 16'hffff, resp);
        check_value("hresp", 16'(resp), 16'd1);
        write_reg(reg_addr_t'(`ADDR_RESULT), 1'b1, 16'h5a5a, resp);
        check_value("hresp", 16'(resp), 16'd1);
        read_reg(reg_addr_t'(`ADDR_STATUS), 1'b1, rd);
        check_value("hrdata status", rd, 16'd0);
        read_reg(reg_addr_t'(`ADDR_RESULT), 1'b1, rd);
        check_value("hrdata result", rd, 16'd0);
        finish_test("read-only registers");

        load_taps();
        finish_test("coefficient load");

        // 13-bit samples keep most results inside the 16-bit range
        for (int n = 0; n < 8; n++) begin
            take_bits(13, v);
            push_and_check(sample_t'({{3{v[12]}}, v[12:0]}));
        end
        finish_test("random samples");

        for (int k = 0; k < `FIR_TAPS; k++) begin
            addr = reg_addr_t'(`ADDR_COEFF0 + 2 * k);
            write_reg(addr, 1'b1, 16'h7fff, resp);
            coeff_regs[k] = 16'h7fff;
        end
        load_taps();
        repeat (4) push_and_check(16'sh7fff);
        check_value("fir_out", uut.fir_out, 16'h7fff);
        repeat (4) push_and_check(16'sh8000);
        check_value("fir_out", uut.fir_out, 16'h8000);
        repeat (4) push_and_check(16'sh0000);

        // Second sample lands while the first is still in the MAC
        shift_history(16'sh0100);
        model_result(exp_out, exp_err);
        write_reg(reg_addr_t'(`ADDR_SAMPLE), 1'b1, 16'sh0100, resp);
        write_reg(reg_addr_t'(`ADDR_SAMPLE), 1'b1, 16'sh0200, resp);
        @(posedge clk);
        @(negedge clk);
        check_value("err", 16'(uut.err), 16'd1);
        check_value("modwait", 16'(uut.modwait), 16'd1);
        wait_idle(cycles);
        check_value("fir_out", uut.fir_out, exp_out);
        read_reg(reg_addr_t'(`ADDR_STATUS), 1'b1, rd);
        check_value("hrdata status", rd, status_expect(1'b0, 1'b1));
        finish_test("saturation and dropped sample");

        $display("Tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/fir_pkg.sv
hdl/ahb_lite_slave.sv
hdl/coefficient_loader.sv
hdl/fir_datapath.sv
hdl/fir_filter_top.sv
sim/tb_fir_filter.sv

//--- Makefile
TOP := tb_fir_filter

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f files.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
